//--- src/switch_pkg.sv
/*
 * Routing switch shared definitions
 * Widths, link counts, direction indices, route field encoding and item type
 */

package switch_pkg;

    //////////////////////////////////////////////////
    // Link and payload sizes
    //////////////////////////////////////////////////

    localparam int DATA_WIDTH = 16;
    localparam int NUM_IN     = 5;
    localparam int NUM_OUT    = 8;

    // Route configuration, one field per output
    localparam int SEL_WIDTH  = 4;
    localparam int CONF_WIDTH = NUM_OUT * SEL_WIDTH;
    localparam int CONF_CHUNK = 8;

    //////////////////////////////////////////////////
    // Input direction indices
    //////////////////////////////////////////////////

    localparam int IN_NW = 0;
    localparam int IN_N  = 1;
    localparam int IN_E  = 2;
    localparam int IN_S  = 3;
    localparam int IN_W  = 4;

    // Configuration chunks arrive on the north link
    localparam int CONF_SRC = IN_N;

    // Field value 0 leaves the output idle, k selects input k-1
    localparam logic [SEL_WIDTH-1:0] SEL_NONE = '0;

    //////////////////////////////////////////////////
    // Buffering and credits
    //////////////////////////////////////////////////

    localparam int FIFO_DEPTH   = 2;
    localparam int DOWN_CREDITS = 2;

    localparam int FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int CREDIT_W   = $clog2(DOWN_CREDITS + 1);

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
    } item_t;

    // One-hot input select of a single output
    typedef logic [NUM_IN-1:0] sel_vec_t;

endpackage

//--- src/config_chain.sv
/*
 * Route configuration chain
 * Shifts a chunk in at the top on every conf_en cycle, so the first chunk
 * ends up in the lowest output fields
 */

`timescale 1ns/10ps

module config_chain (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             conf_en,
    input  logic [switch_pkg::CONF_CHUNK-1:0] conf_data,
    output logic [switch_pkg::CONF_WIDTH-1:0] route_conf
);

    localparam int CW = switch_pkg::CONF_WIDTH;
    localparam int CC = switch_pkg::CONF_CHUNK;

    // Cleared config leaves every output idle
    always_ff @(posedge clk) begin
        if (rst) begin
            route_conf <= '0;
        end else if (conf_en) begin
            route_conf <= {conf_data, route_conf[CW-1:CC]};
        end
    end

endmodule

//--- src/output_port.sv
/*
 * Switch output port
 * Picks one input by its route field, buffers items in a small FIFO and
 * forwards them while downstream credits remain
 */

`timescale 1ns/10ps

module output_port (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            conf_en,
    input  logic [switch_pkg::SEL_WIDTH-1:0] route_sel,
    input  switch_pkg::item_t               in_item [switch_pkg::NUM_IN],
    output switch_pkg::sel_vec_t            sel,
    output switch_pkg::item_t               out_item,
    input  logic                            out_credit,
    output logic                            deq
);

    localparam int NUM_IN = switch_pkg::NUM_IN;
    localparam int DEPTH  = switch_pkg::FIFO_DEPTH;
    localparam int PTR_W  = switch_pkg::FIFO_PTR_W;
    localparam int CNT_W  = switch_pkg::FIFO_CNT_W;
    localparam int CRD_W  = switch_pkg::CREDIT_W;

    switch_pkg::item_t             picked;
    logic                          wr_en;
    logic                          full;
    logic [switch_pkg::DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]              wr_ptr;
    logic [PTR_W-1:0]              rd_ptr;
    logic [CNT_W-1:0]              count;
    logic [CRD_W-1:0]              credits;

    //////////////////////////////////////////////////
    // Route decode and input mux
    //////////////////////////////////////////////////

    always_comb begin
        sel    = '0;
        picked = '0;
        if (route_sel != switch_pkg::SEL_NONE) begin
            for (int k = 0; k < NUM_IN; k++) begin
                if (route_sel == switch_pkg::SEL_WIDTH'(k + 1)) begin
                    sel[k] = 1'b1;
                    picked = in_item[k];
                end
            end
        end
    end

    // Nothing is routed while the chain is loading
    assign wr_en = picked.valid && !conf_en;
    assign full  = (count == CNT_W'(DEPTH));

    //////////////////////////////////////////////////
    // Item FIFO
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= picked.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (deq) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Downstream credits and output
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRD_W'(switch_pkg::DOWN_CREDITS);
        end else begin
            case ({deq, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Head goes out in any cycle with data and a credit in hand
    assign deq            = (count != '0) && (credits != '0);
    assign out_item.valid = deq;
    assign out_item.data  = mem[rd_ptr];

    // Upstream must never send past the credits it was given
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        !(wr_en && full));

    // Downstream returns at most what it was handed
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= CRD_W'(switch_pkg::DOWN_CREDITS));

endmodule

//--- src/credit_join.sv
/*
 * Upstream credit join for one input
 * Returns a credit once every output fed by this input has sent its copy
 */

`timescale 1ns/10ps

module credit_join (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [switch_pkg::NUM_OUT-1:0] sel_col,
    input  logic [switch_pkg::NUM_OUT-1:0] deq,
    output logic                          credit
);

    localparam int NUM_OUT = switch_pkg::NUM_OUT;

    logic [NUM_OUT-1:0] saved;
    logic [NUM_OUT-1:0] done;

    //////////////////////////////////////////////////
    // Completion tracking
    //////////////////////////////////////////////////

    // Unselected outputs count as done
    assign done   = ~sel_col | saved | deq;
    assign credit = (&done) && (|sel_col);

    // Remember early copies until the slowest output catches up
    always_ff @(posedge clk) begin
        if (rst) begin
            saved <= '0;
        end else if (credit) begin
            saved <= '0;
        end else begin
            saved <= saved | (deq & sel_col);
        end
    end

    // Pending copies only belong to outputs that this input still feeds
    a_saved_selected: assert property (@(posedge clk) disable iff (rst)
        (saved & ~sel_col) == '0);

endmodule

//--- src/dyser_switch.sv
/*
 * Credit flow controlled routing switch
 * Five input links, eight output links, chain-loaded route configuration
 * with multicast and joined upstream credits
 */

`timescale 1ns/10ps

module dyser_switch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          conf_en,
    input  switch_pkg::item_t             in_item [switch_pkg::NUM_IN],
    output logic [switch_pkg::NUM_IN-1:0]  in_credit,
    output switch_pkg::item_t             out_item [switch_pkg::NUM_OUT],
    input  logic [switch_pkg::NUM_OUT-1:0] out_credit
);

    localparam int NUM_IN    = switch_pkg::NUM_IN;
    localparam int NUM_OUT   = switch_pkg::NUM_OUT;
    localparam int SEL_WIDTH = switch_pkg::SEL_WIDTH;

    logic [switch_pkg::CONF_WIDTH-1:0] route_conf;
    switch_pkg::sel_vec_t              sel_all [NUM_OUT];
    logic [NUM_OUT-1:0]                deq_all;
    logic [NUM_OUT-1:0]                sel_col [NUM_IN];

    //////////////////////////////////////////////////
    // Configuration chain
    //////////////////////////////////////////////////

    config_chain u_config_chain (
        .clk        (clk),
        .rst        (rst),
        .conf_en    (conf_en),
        .conf_data  (in_item[switch_pkg::CONF_SRC].data[switch_pkg::CONF_CHUNK-1:0]),
        .route_conf (route_conf)
    );

    //////////////////////////////////////////////////
    // Output ports
    //////////////////////////////////////////////////

    for (genvar j = 0; j < NUM_OUT; j++) begin : g_out
        output_port u_output_port (
            .clk        (clk),
            .rst        (rst),
            .conf_en    (conf_en),
            .route_sel  (route_conf[j*SEL_WIDTH +: SEL_WIDTH]),
            .in_item    (in_item),
            .sel        (sel_all[j]),
            .out_item   (out_item[j]),
            .out_credit (out_credit[j]),
            .deq        (deq_all[j])
        );
    end

    //////////////////////////////////////////////////
    // Credit joins, one per input
    //////////////////////////////////////////////////

    // Column i gathers input i's select bit from every output
    for (genvar i = 0; i < NUM_IN; i++) begin : g_in
        for (genvar j = 0; j < NUM_OUT; j++) begin : g_col
            assign sel_col[i][j] = sel_all[j][i];
        end

        credit_join u_credit_join (
            .clk     (clk),
            .rst     (rst),
            .sel_col (sel_col[i]),
            .deq     (deq_all),
            .credit  (in_credit[i])
        );
    end

endmodule

//--- bench/switch_tb.sv
/*
 * Routing switch testbench
 * Loads route configurations from a step table, sends items under credit
 * flow control and checks every output against a cycle reference model
 */

`timescale 1ns/10ps

module switch_tb;

    localparam int NUM_IN    = switch_pkg::NUM_IN;
    localparam int NUM_OUT   = switch_pkg::NUM_OUT;
    localparam int TIMEOUT   = 200;
    localparam int NUM_STEPS = 6;

    typedef struct packed {
        logic [31:0] conf;     // Eight route fields with output 0 in the low nibble
        logic [2:0]  src;      // Input that carries the items
        logic [3:0]  n_items;
        logic        multi;    // Keep a single item in flight
        logic [31:0] hold;     // Per-output credit hold in units of 4 cycles
        logic [7:0]  mask;     // Outputs expected to deliver
    } step_t;

    logic                     clk;
    logic                     rst;
    logic                     conf_en;
    switch_pkg::item_t        in_item [NUM_IN];
    logic [NUM_IN-1:0]        in_credit;
    switch_pkg::item_t        out_item [NUM_OUT];
    logic [NUM_OUT-1:0]       out_credit;

    step_t steps [NUM_STEPS];

    // Reference model state
    int exp_q [NUM_OUT][$];
    int item_data [256];
    int item_src [256];
    int item_left [256];
    int n_seq;
    int mcred [NUM_OUT];
    int model_sel [NUM_OUT];
    int deliveries [NUM_OUT];
    int cred_cnt [NUM_IN];
    int cycle;

    // Upstream and downstream bookkeeping
    int sent_cnt [NUM_IN];
    int release_at [NUM_OUT];
    int returned [NUM_OUT];

    int item_errors;
    int credit_errors;
    int count_errors;
    int timeouts;
    bit timed_out;

    dyser_switch u_dyser_switch (
        .clk        (clk),
        .rst        (rst),
        .conf_en    (conf_en),
        .in_item    (in_item),
        .in_credit  (in_credit),
        .out_item   (out_item),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Compare tasks and helpers
    //////////////////////////////////////////////////

    task automatic check_item(input int idx, input switch_pkg::item_t got,
                              input switch_pkg::item_t exp);
        if (got.valid !== exp.valid || (exp.valid && got.data !== exp.data)) begin
            item_errors++;
            $display("FAILED t=%0t out_item[%0d] got %h expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_credit(input logic [NUM_IN-1:0] got, input logic [NUM_IN-1:0] exp);
        if (got !== exp) begin
            credit_errors++;
            $display("FAILED t=%0t in_credit got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            count_errors++;
            $display("FAILED t=%0t %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic switch_pkg::item_t make_item(input logic v, input logic [15:0] d);
        switch_pkg::item_t it;
        it.valid = v;
        it.data  = d;
        return it;
    endfunction

    function automatic bit drained(input int src, input bit need_cred);
        bit ok;
        ok = 1'b1;
        for (int j = 0; j < NUM_OUT; j++) begin
            if (exp_q[j].size() != 0 || mcred[j] != switch_pkg::DOWN_CREDITS) begin
                ok = 1'b0;
            end
        end
        if (need_cred && sent_cnt[src] != cred_cnt[src]) begin
            ok = 1'b0;
        end
        return ok;
    endfunction

    //////////////////////////////////////////////////
    // Reference model sampled on the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk) begin : model_check
        logic [NUM_IN-1:0] exp_cred;
        switch_pkg::item_t exp_it;
        logic              v;
        int                s;
        if (rst) begin
            n_seq = 0;
            cycle = 0;
            for (int j = 0; j < NUM_OUT; j++) begin
                exp_q[j].delete();
                mcred[j]      = switch_pkg::DOWN_CREDITS;
                model_sel[j]  = 0;
                deliveries[j] = 0;
            end
            for (int i = 0; i < NUM_IN; i++) begin
                cred_cnt[i] = 0;
            end
        end else begin
            cycle++;
            exp_cred = '0;
            // Head leaves whenever data and a downstream credit are both present
            for (int j = 0; j < NUM_OUT; j++) begin
                v = (exp_q[j].size() > 0) && (mcred[j] > 0);
                exp_it.valid = v;
                exp_it.data  = v ? 16'(item_data[exp_q[j][0]]) : 16'h0;
                check_item(j, out_item[j], exp_it);
                if (v) begin
                    s = exp_q[j].pop_front();
                    item_left[s]--;
                    if (item_left[s] == 0) begin
                        exp_cred[item_src[s]] = 1'b1;
                    end
                    deliveries[j]++;
                end
                mcred[j] = mcred[j] - (v ? 1 : 0) + (out_credit[j] ? 1 : 0);
            end
            check_credit(in_credit, exp_cred);
            for (int i = 0; i < NUM_IN; i++) begin
                if (in_credit[i]) begin
                    cred_cnt[i]++;
                end
            end
            // Accepted items fan out to every output that selects them
            if (!conf_en) begin
                for (int i = 0; i < NUM_IN; i++) begin
                    if (in_item[i].valid) begin
                        item_data[n_seq] = int'(in_item[i].data);
                        item_src[n_seq]  = i;
                        item_left[n_seq] = 0;
                        for (int j = 0; j < NUM_OUT; j++) begin
                            if (model_sel[j] == i + 1) begin
                                exp_q[j].push_back(n_seq);
                                item_left[n_seq]++;
                            end
                        end
                        n_seq++;
                    end
                end
            end
        end
    end

    // Downstream receivers hand back one credit per delivery after their hold
    initial begin : downstream
        out_credit = '0;
        forever begin
            @(posedge clk);
            for (int j = 0; j < NUM_OUT; j++) begin
                if (rst) begin
                    returned[j] = 0;
                    out_credit[j] <= 1'b0;
                end else if (cycle >= release_at[j] && deliveries[j] > returned[j]) begin
                    returned[j]++;
                    out_credit[j] <= 1'b1;
                end else begin
                    out_credit[j] <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic load_config(input logic [31:0] conf);
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            conf_en <= 1'b1;
            // Valid items on every link that must not be routed
            for (int k = 0; k < NUM_IN; k++) begin
                in_item[k] <= make_item(1'b1, 16'($urandom));
            end
            in_item[switch_pkg::CONF_SRC] <= make_item(1'b1, {8'($urandom), conf[8*c +: 8]});
        end
        @(posedge clk);
        conf_en <= 1'b0;
        for (int k = 0; k < NUM_IN; k++) begin
            in_item[k] <= make_item(1'b0, 16'h0);
        end
        for (int j = 0; j < NUM_OUT; j++) begin
            model_sel[j] = int'(conf[4*j +: 4]);
        end
    endtask

    task automatic send_items(input int src, input int n, input bit multi);
        int sent_now;
        int guard;
        int avail;
        sent_now = 0;
        guard    = 0;
        while (sent_now < n && guard < TIMEOUT) begin
            @(posedge clk);
            avail = switch_pkg::FIFO_DEPTH - sent_cnt[src] + cred_cnt[src];
            if (avail > 0 && (!multi || avail == switch_pkg::FIFO_DEPTH)) begin
                in_item[src] <= make_item(1'b1, 16'($urandom));
                sent_cnt[src]++;
                sent_now++;
                guard = 0;
            end else begin
                in_item[src] <= make_item(1'b0, 16'h0);
                guard++;
            end
        end
        @(posedge clk);
        in_item[src] <= make_item(1'b0, 16'h0);
        if (sent_now < n) begin
            $display("Timed out waiting for upstream credit on input %0d", src);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_drain(input int src, input bit need_cred);
        int guard;
        bit done;
        guard = 0;
        done  = 1'b0;
        while (!done && guard < TIMEOUT) begin
            @(posedge clk);
            done = drained(src, need_cred);
            guard++;
        end
        if (!done) begin
            $display("Timed out waiting for the switch to drain, input %0d", src);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_step(input int r);
        int src;
        int n;
        int cbase;
        int dbase [NUM_OUT];
        src = int'(steps[r].src);
        n   = int'(steps[r].n_items);
        load_config(steps[r].conf);
        for (int j = 0; j < NUM_OUT; j++) begin
            release_at[j] = cycle + 4 * int'(steps[r].hold[4*j +: 4]);
            dbase[j]      = deliveries[j];
        end
        cbase = cred_cnt[src];
        send_items(src, n, steps[r].multi);
        if (!timed_out) begin
            wait_drain(src, steps[r].mask != 8'h0);
        end
        if (!timed_out) begin
            for (int j = 0; j < NUM_OUT; j++) begin
                check_count($sformatf("step %0d deliveries on output %0d", r, j),
                            deliveries[j] - dbase[j], steps[r].mask[j] ? n : 0);
            end
            check_count($sformatf("step %0d in_credit pulses on input %0d", r, src),
                        cred_cnt[src] - cbase, (steps[r].mask != 8'h0) ? n : 0);
        end
    endtask

    task automatic finish_run;
        $display("Errors: item %0d, credit %0d, count %0d, timeouts %0d",
                 item_errors, credit_errors, count_errors, timeouts);
        if (item_errors == 0 && credit_errors == 0 && count_errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin : main
        void'($urandom(44));
        rst      = 1'b1;
        conf_en  = 1'b0;
        for (int k = 0; k < NUM_IN; k++) begin
            in_item[k]  = make_item(1'b0, 16'h0);
            sent_cnt[k] = 0;
        end
        for (int j = 0; j < NUM_OUT; j++) begin
            release_at[j] = 0;
        end
        item_errors   = 0;
        credit_errors = 0;
        count_errors  = 0;
        timeouts      = 0;
        timed_out     = 1'b0;

        // Unicast with free credits
        steps[0] = '{conf: 32'h0000_0010, src: 3'(switch_pkg::IN_NW), n_items: 4'd3,
                     multi: 1'b0, hold: 32'h0, mask: 8'h02};
        steps[1] = '{conf: 32'h0003_0000, src: 3'(switch_pkg::IN_E), n_items: 4'd3,
                     multi: 1'b0, hold: 32'h0, mask: 8'h10};
        // Multicast to ne, e, se with staggered credit release
        steps[2] = '{conf: 32'h0005_5500, src: 3'(switch_pkg::IN_W), n_items: 4'd3,
                     multi: 1'b1, hold: 32'h0005_2000, mask: 8'h1C};
        // Back-pressure on the south output
        steps[3] = '{conf: 32'h0040_0000, src: 3'(switch_pkg::IN_S), n_items: 4'd4,
                     multi: 1'b0, hold: 32'h0080_0000, mask: 8'h20};
        steps[4] = '{conf: 32'h2200_0002, src: 3'(switch_pkg::IN_N), n_items: 4'd4,
                     multi: 1'b1, hold: 32'h0, mask: 8'hC1};
        // Items on an input no output selects, so its credits stay spent
        steps[5] = '{conf: 32'h0000_0010, src: 3'(switch_pkg::IN_S), n_items: 4'd2,
                     multi: 1'b0, hold: 32'h0, mask: 8'h00};

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int r = 0; r < NUM_STEPS; r++) begin
            if (!timed_out) begin
                run_step(r);
            end
        end
        finish_run();
    end

endmodule

//--- compile.f
src/switch_pkg.sv
src/config_chain.sv
src/output_port.sv
src/credit_join.sv
src/dyser_switch.sv
bench/switch_tb.sv

//--- Makefile
BIN  := obj_dir/Vswitch_tb
SRCS := src/switch_pkg.sv src/config_chain.sv src/output_port.sv \
        src/credit_join.sv src/dyser_switch.sv bench/switch_tb.sv

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

$(BIN): compile.f $(SRCS)
	verilator --binary --timing --assert -f compile.f --top-module switch_tb -o Vswitch_tb

clean:
	rm -rf obj_dir
